/* logic/rvPredecode_config.svh */
`ifndef RVPD_CONFIG_SVH
`define RVPD_CONFIG_SVH

// ******************************
// Register map
// ******************************
`define CTRL_OFS    8'h00 // Control bits compressedEn, countEn, clear
`define TOTAL_OFS   8'h04 // All accepted results
`define JUMP_OFS    8'h08
`define LOAD_OFS    8'h0C
`define STORE_OFS   8'h10
`define ILLEGAL_OFS 8'h14

// ******************************
// Event counters
// ******************************
`define CNT_W 32

`endif

/* logic/rvPredecodePkg.sv */
package rvPredecodePkg;

  // ******************************
  // Plain vectors
  // ******************************
  typedef logic [31:0] instrWord_t;
  typedef logic [10:0] classVec_t; // Bit 0 alu up to bit 10 illegal
  typedef logic [4:0]  regAddr_t;
  typedef logic [7:0]  axiAddr_t;
  typedef logic [31:0] axiData_t;

  // ******************************
  // Predecode result and beat
  // ******************************
  typedef struct packed {
    classVec_t cls;
    logic      isLink;
    logic      isRet;
    logic      isCompressed;
  } predecInfo_t;

  typedef struct packed {
    instrWord_t  instr;
    predecInfo_t info;
  } fetchBeat_t;

  // ******************************
  // AXI4-Lite register port
  // ******************************
  typedef struct packed {
    logic       awValid;
    axiAddr_t   awAddr;
    logic       wValid;
    axiData_t   wData;
    logic [3:0] wStrb;
    logic       bReady;
    logic       arValid;
    axiAddr_t   arAddr;
    logic       rReady;
  } axiLiteReq_t;

  typedef struct packed {
    logic       awReady;
    logic       wReady;
    logic       bValid;
    logic [1:0] bResp;
    logic       arReady;
    logic       rValid;
    axiData_t   rData;
    logic [1:0] rResp;
  } axiLiteRsp_t;

endpackage

/* logic/rvClassDecode.sv */
`timescale 1ns/100ps

module rvClassDecode (
  input  rvPredecodePkg::instrWord_t  instr,
  input  logic                        compressedEn,
  output rvPredecodePkg::predecInfo_t info
);

  function automatic logic isLinkReg(input rvPredecodePkg::regAddr_t r);
    return (r == 5'd1) || (r == 5'd5);
  endfunction

  logic fullWord;
  logic compWord;
  logic q0, q1, q2;
  logic [2:0] cF3;
  logic [4:0] op;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rvPredecodePkg::regAddr_t rdIdx;
  rvPredecodePkg::regAddr_t rs1Idx;
  rvPredecodePkg::regAddr_t rs2C;

  assign fullWord = instr[1:0] == 2'b11;
  assign compWord = !fullWord;
  assign q0 = compressedEn && instr[1:0] == 2'b00;
  assign q1 = compressedEn && instr[1:0] == 2'b01;
  assign q2 = compressedEn && instr[1:0] == 2'b10;
  assign cF3 = instr[15:13];
  assign op = instr[6:2];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rdIdx = instr[11:7]; // Also rd/rs1 of the compressed formats
  assign rs1Idx = instr[19:15];
  assign rs2C = instr[6:2];

  // ******************************
  // Compressed quadrant terms
  // ******************************
  logic subAddi4, subLdSt, subLoad, subStore, subFpMem;
  logic subQ1Alu, subQ1Arith, subQ1Jmp, subQ2Slli;
  logic subQ2Misc, subJr, subEbreak, subMvAdd;

  assign subAddi4 = q0 && cF3 == 3'b000 && instr[12:5] != 8'b0;
  assign subLdSt = (q0 || q2) && cF3[1:0] != 2'b00; // Both quadrants share the layout
  assign subLoad = subLdSt && !cF3[2];
  assign subStore = subLdSt && cF3[2];
  assign subFpMem = subLdSt && cF3[1:0] == 2'b01;
  assign subQ1Alu = q1 && !cF3[2];
  assign subQ1Arith = q1 && cF3 == 3'b100;
  assign subQ1Jmp = q1 && (cF3 == 3'b101 || cF3[2:1] == 2'b11);
  assign subQ2Slli = q2 && cF3 == 3'b000;
  assign subQ2Misc = q2 && cF3 == 3'b100;
  assign subJr = subQ2Misc && rs2C == 5'b0 && rdIdx != 5'b0; // c.jr or c.jalr
  assign subEbreak = subQ2Misc && rs2C == 5'b0 && rdIdx == 5'b0 && instr[12];
  assign subMvAdd = subQ2Misc && rs2C != 5'b0;

  // ******************************
  // Full opcode terms
  // ******************************
  logic isLoad, isStore, isIntOp, isRegOp, isUpper;
  logic isBranch, isJal, isJalr, isSys, isFpu;
  logic fullMul, fullShift, fullAlu;

  assign isLoad = fullWord && op[4:1] == 4'b0000;
  assign isStore = fullWord && op[4:1] == 4'b0100;
  assign isIntOp = fullWord && !op[4] && op[2] && !op[0]; // OP-IMM, OP-IMM-32, OP, OP-32
  assign isRegOp = isIntOp && op[3];
  assign isUpper = fullWord && !op[4] && op[2:0] == 3'b101;
  assign isBranch = fullWord && op == 5'b11000;
  assign isJal = fullWord && op == 5'b11011;
  assign isJalr = fullWord && op == 5'b11001;
  assign isSys = fullWord && op == 5'b11100;
  assign isFpu = fullWord && (op == 5'b10100 || op[4:2] == 3'b100);

  assign fullMul = isRegOp && funct7 == 7'b0000001; // MULH shares funct3 with shifts
  assign fullShift = isIntOp && funct3[1:0] == 2'b01 && !fullMul;
  assign fullAlu = (isIntOp && !fullShift && !fullMul) || isUpper;

  // ******************************
  // Class bits and hints
  // ******************************
  logic clsAlu, clsShift, clsMul, clsLoad, clsStore, clsFpMem;
  logic clsFpu, clsJump, clsIndir, clsSys, clsIllegal;

  assign clsAlu = |{subAddi4, subQ1Alu, subQ1Arith && instr[11], subMvAdd, fullAlu};
  assign clsShift = |{subQ1Arith && !instr[11], subQ2Slli, fullShift};
  assign clsMul = fullMul;
  assign clsLoad = |{subLoad, isLoad};
  assign clsStore = |{subStore, isStore};
  assign clsFpMem = |{subFpMem, (isLoad || isStore) && op[0]};
  assign clsFpu = isFpu;
  assign clsJump = |{subQ1Jmp, subJr, isBranch, isJal, isJalr};
  assign clsIndir = |{subJr, isJalr};
  assign clsSys = |{subEbreak, isSys};
  assign clsIllegal = !(|{clsAlu, clsShift, clsMul, clsLoad, clsStore, clsFpu, clsJump, clsSys})
                      || (compWord && !compressedEn);

  always_comb begin
    info.cls = {clsIllegal, clsSys, clsIndir, clsJump, clsFpu, clsFpMem,
                clsStore, clsLoad, clsMul, clsShift, clsAlu};
    info.isLink = ((isJal || isJalr) && isLinkReg(rdIdx)) || (subJr && instr[12]);
    info.isRet = (isJalr && rdIdx == 5'b0 && isLinkReg(rs1Idx))
                 || (subJr && !instr[12] && isLinkReg(rdIdx));
    info.isCompressed = compWord;
  end

endmodule

/* logic/predecodePipe.sv */
`timescale 1ns/100ps

module predecodePipe (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       inValid,
  output logic                       inReady,
  input  rvPredecodePkg::fetchBeat_t inBeat,
  output logic                       outValid,
  input  logic                       outReady,
  output rvPredecodePkg::fetchBeat_t outBeat,
  output logic                       acceptPulse,
  output rvPredecodePkg::classVec_t  acceptCls
);

  logic                       full;
  rvPredecodePkg::fetchBeat_t beatQ;

  // ******************************
  // Handshake
  // ******************************
  assign inReady = !full || outReady; // Refill in the cycle the beat leaves
  assign outValid = full;
  assign outBeat = beatQ;

  // Output transfer report for the event counters
  assign acceptPulse = full && outReady;
  assign acceptCls = beatQ.info.cls;

  // ******************************
  // Storage
  // ******************************
  always_ff @(posedge clk) begin
    if (!rstN) begin
      full <= 1'b0;
    end else if (inReady) begin
      full <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      beatQ <= inBeat; // Held while stalled
    end
  end

endmodule

/* logic/predecodeCsr.sv */
`timescale 1ns/100ps

`include "rvPredecode_config.svh"

module predecodeCsr (
  input  logic                        clk,
  input  logic                        rstN,
  input  rvPredecodePkg::axiLiteReq_t axiReq,
  output rvPredecodePkg::axiLiteRsp_t axiRsp,
  output logic                        compressedEn,
  input  logic                        acceptPulse,
  input  rvPredecodePkg::classVec_t   acceptCls
);

  logic                     compressedEnQ;
  logic                     countEnQ;
  logic                     bValidQ;
  logic                     rValidQ;
  rvPredecodePkg::axiData_t rDataQ;
  rvPredecodePkg::axiData_t rdMux;
  logic                     wrAccept;
  logic                     rdAccept;
  logic                     ctrlWrite;
  logic                     cntClr;
  logic [4:0]               evHit;
  logic [`CNT_W-1:0]        evCnt [5]; // Total, jump, load, store, illegal

  // ******************************
  // Write channel
  // ******************************
  assign wrAccept = axiReq.awValid && axiReq.wValid && !bValidQ;
  assign ctrlWrite = wrAccept && axiReq.awAddr == `CTRL_OFS && axiReq.wStrb[0];
  assign cntClr = ctrlWrite && axiReq.wData[2];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      compressedEnQ <= 1'b1;
      countEnQ <= 1'b0;
    end else if (ctrlWrite) begin
      compressedEnQ <= axiReq.wData[0];
      countEnQ <= axiReq.wData[1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      bValidQ <= 1'b0;
    end else if (wrAccept) begin
      bValidQ <= 1'b1;
    end else if (axiReq.bReady) begin
      bValidQ <= 1'b0;
    end
  end

  // ******************************
  // Event counters
  // ******************************
  // Class bits 7 jump, 3 load, 4 store, 10 illegal
  assign evHit = {acceptCls[10], acceptCls[4], acceptCls[3], acceptCls[7], 1'b1};

  always_ff @(posedge clk) begin
    for (int i = 0; i < 5; i++) begin
      if (!rstN || cntClr) begin
        evCnt[i] <= '0; // Clear wins over a same-cycle transfer
      end else if (countEnQ && acceptPulse && evHit[i]) begin
        evCnt[i] <= evCnt[i] + 1'b1;
      end
    end
  end

  // ******************************
  // Read channel
  // ******************************
  always_comb begin
    rdMux = '0;
    case (axiReq.arAddr)
      `CTRL_OFS:    rdMux = rvPredecodePkg::axiData_t'({countEnQ, compressedEnQ});
      `TOTAL_OFS:   rdMux = rvPredecodePkg::axiData_t'(evCnt[0]);
      `JUMP_OFS:    rdMux = rvPredecodePkg::axiData_t'(evCnt[1]);
      `LOAD_OFS:    rdMux = rvPredecodePkg::axiData_t'(evCnt[2]);
      `STORE_OFS:   rdMux = rvPredecodePkg::axiData_t'(evCnt[3]);
      `ILLEGAL_OFS: rdMux = rvPredecodePkg::axiData_t'(evCnt[4]);
      default:      rdMux = '0; // Unmapped reads as zero
    endcase
  end

  assign rdAccept = axiReq.arValid && !rValidQ;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rValidQ <= 1'b0;
    end else if (rdAccept) begin
      rValidQ <= 1'b1;
    end else if (axiReq.rReady) begin
      rValidQ <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rDataQ <= rdMux;
    end
  end

  always_comb begin
    axiRsp.awReady = wrAccept;
    axiRsp.wReady = wrAccept;
    axiRsp.bValid = bValidQ;
    axiRsp.bResp = 2'b00; // OKAY
    axiRsp.arReady = !rValidQ;
    axiRsp.rValid = rValidQ;
    axiRsp.rData = rDataQ;
    axiRsp.rResp = 2'b00;
  end

  assign compressedEn = compressedEnQ;

endmodule

/* logic/rvPredecodeTop.sv */
`timescale 1ns/100ps

module rvPredecodeTop (
  input  logic                        clk,
  input  logic                        rstN,
  input  logic                        inValid,
  output logic                        inReady,
  input  rvPredecodePkg::instrWord_t  inInstr,
  output logic                        outValid,
  input  logic                        outReady,
  output rvPredecodePkg::fetchBeat_t  outBeat,
  input  rvPredecodePkg::axiLiteReq_t axiReq,
  output rvPredecodePkg::axiLiteRsp_t axiRsp
);

  rvPredecodePkg::predecInfo_t decInfo;
  rvPredecodePkg::fetchBeat_t  inBeat;
  rvPredecodePkg::classVec_t   acceptCls;
  logic                        acceptPulse;
  logic                        compressedEn;

  assign inBeat = '{instr: inInstr, info: decInfo};

  // ******************************
  // Datapath
  // ******************************
  rvClassDecode u_rvClassDecode (
    .instr        (inInstr),
    .compressedEn (compressedEn),
    .info         (decInfo)
  );

  predecodePipe u_predecodePipe (
    .clk         (clk),
    .rstN        (rstN),
    .inValid     (inValid),
    .inReady     (inReady),
    .inBeat      (inBeat),
    .outValid    (outValid),
    .outReady    (outReady),
    .outBeat     (outBeat),
    .acceptPulse (acceptPulse),
    .acceptCls   (acceptCls)
  );

  // ******************************
  // Register block
  // ******************************
  predecodeCsr u_predecodeCsr (
    .clk          (clk),
    .rstN         (rstN),
    .axiReq       (axiReq),
    .axiRsp       (axiRsp),
    .compressedEn (compressedEn),
    .acceptPulse  (acceptPulse),
    .acceptCls    (acceptCls)
  );

endmodule

/* dv/tbClockGen.sv */
`timescale 1ns/100ps

module tbClockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rstN = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

/* dv/rvPredecode_assertions.sv */
`timescale 1ns/100ps

module rvPredecode_assertions (
  input logic                        clk,
  input logic                        rstN,
  input logic                        inReady,
  input logic                        outValid,
  input logic                        outReady,
  input rvPredecodePkg::fetchBeat_t  outBeat,
  input rvPredecodePkg::axiLiteReq_t axiReq,
  input rvPredecodePkg::axiLiteRsp_t axiRsp
);

  int failCount = 0; // Read by the testbench summary

  // ******************************
  // Handshake rules
  // ******************************
  outHoldsWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outBeat))
    else begin
      failCount++;
      $error("outValid dropped or outBeat changed while outReady was low");
    end

  bValidHeld: assert property (@(posedge clk) disable iff (!rstN)
    axiRsp.bValid && !axiReq.bReady |=> axiRsp.bValid)
    else begin
      failCount++;
      $error("bValid dropped before bReady");
    end

  rValidHeld: assert property (@(posedge clk) disable iff (!rstN)
    axiRsp.rValid && !axiReq.rReady |=> axiRsp.rValid)
    else begin
      failCount++;
      $error("rValid dropped before rReady");
    end

  controlKnown: assert property (@(posedge clk) disable iff (!rstN)
    !$isunknown({inReady, outValid, axiRsp.awReady, axiRsp.wReady, axiRsp.bValid,
                 axiRsp.arReady, axiRsp.rValid}))
    else begin
      failCount++;
      $error("A control output is X after reset");
    end

endmodule

/* dv/rvPredecodeTb.sv */
`timescale 1ns/100ps

`include "rvPredecode_config.svh"

module rvPredecodeTb;

  localparam int numRandBeats = 3000;
  localparam int numOffBeats = 400;
  localparam int numDirBeats = 11;
  localparam int timeoutCycles = (numRandBeats + numOffBeats + numDirBeats) * 8 + 2000;
  localparam int numTpl = 25;
  localparam int respWait = 50; // Cycles before a missing AXI response is reported
  localparam int respStall = 2; // Cycles a response waits for its ready

  logic clk;
  logic rstN;
  logic inValid;
  logic inReady;
  logic outValid;
  logic outReady;
  rvPredecodePkg::instrWord_t  inInstr;
  rvPredecodePkg::fetchBeat_t  outBeat;
  rvPredecodePkg::axiLiteReq_t axiReq;
  rvPredecodePkg::axiLiteRsp_t axiRsp;

  logic [31:0] rndState;
  rvPredecodePkg::fetchBeat_t expQ [$];
  rvPredecodePkg::fetchBeat_t expBeat;
  rvPredecodePkg::fetchBeat_t newBeat;
  logic compEnM;
  logic countEnM;
  rvPredecodePkg::axiData_t totalM, jumpM, loadM, storeM, illegalM;
  rvPredecodePkg::axiData_t rdData;
  int valueErrs = 0;
  int protoErrs = 0;
  int beatsChecked = 0;
  int cycles = 0;

  // Opcode templates as {mask, value}; bits outside the mask get random fill
  logic [63:0] tpl [numTpl] = '{
    {32'h7F, 32'h03}, {32'h7F, 32'h07}, {32'h7F, 32'h23}, {32'h7F, 32'h27},
    {32'h7F, 32'h13}, {32'h7F, 32'h1B}, {32'h7F, 32'h33}, {32'h7F, 32'h3B},
    {32'h7F, 32'h37}, {32'h7F, 32'h17}, {32'h7F, 32'h63}, {32'h7F, 32'h6F},
    {32'h7F, 32'h67}, {32'h7F, 32'h73}, {32'h7F, 32'h53}, {32'h7F, 32'h43},
    {32'h7F, 32'h0B}, {32'hFE00007F, 32'h02000033}, {32'hFE00007F, 32'h0200003B},
    {32'h707F, 32'h1013}, {32'h3, 32'h0}, {32'h3, 32'h1}, {32'h3, 32'h2},
    {32'hE07F, 32'h8002}, {32'hFFE3, 32'h0}
  };

  // JAL, JALR, c.jr, c.jalr and c.ebreak hint cases
  rvPredecodePkg::instrWord_t dirWords [numDirBeats] = '{
    32'h000000EF, 32'h0000006F, 32'h000280E7, 32'h00008067, 32'h00028067, 32'h00030067,
    32'h00008082, 32'h00009082, 32'h00008282, 32'h00008302, 32'h00009002
  };

  tbClockGen u_tbClockGen (
    .clk  (clk),
    .rstN (rstN)
  );

  rvPredecodeTop u_rvPredecodeTop (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inReady  (inReady),
    .inInstr  (inInstr),
    .outValid (outValid),
    .outReady (outReady),
    .outBeat  (outBeat),
    .axiReq   (axiReq),
    .axiRsp   (axiRsp)
  );

  bind rvPredecodeTop rvPredecode_assertions u_rvPredecodeAssertions (
    .clk      (clk),
    .rstN     (rstN),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outBeat  (outBeat),
    .axiReq   (axiReq),
    .axiRsp   (axiRsp)
  );

  // ******************************
  // Random numbers and reference
  // ******************************
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rndState = xorshift32(rndState);
    return rndState;
  endfunction

  function automatic rvPredecodePkg::instrWord_t genInstr();
    int idx;
    logic [31:0] fill;
    idx = int'(nextRand() % numTpl);
    fill = nextRand();
    return (fill & ~tpl[idx][63:32]) | tpl[idx][31:0];
  endfunction

  function automatic logic linkReg(input rvPredecodePkg::regAddr_t r);
    return r == 5'd1 || r == 5'd5;
  endfunction

  // Class bits: 0 alu, 1 shift, 2 mul, 3 load, 4 store, 5 fpMem, 6 fpu, 7 jump, 8 indir,
  // 9 sys, 10 illegal
  function automatic rvPredecodePkg::predecInfo_t refPredecode(
    input rvPredecodePkg::instrWord_t w, input logic compEn);
    rvPredecodePkg::predecInfo_t r;
    rvPredecodePkg::classVec_t c;
    rvPredecodePkg::regAddr_t rd;
    logic [2:0] f3;
    r = '0;
    c = '0;
    rd = w[11:7];
    r.isCompressed = w[1:0] != 2'b11;
    if (!r.isCompressed) begin
      f3 = w[14:12];
      case (w[6:2])
        5'b00000: c[3] = 1'b1;
        5'b00001: c[5:3] = 3'b101;
        5'b01000: c[4] = 1'b1;
        5'b01001: c[5:4] = 2'b11;
        5'b00100, 5'b00110, 5'b01100, 5'b01110: begin
          if (w[5] && w[31:25] == 7'b0000001) c[2] = 1'b1;
          else if (f3 == 3'b001 || f3 == 3'b101) c[1] = 1'b1;
          else c[0] = 1'b1;
        end
        5'b01101, 5'b00101: c[0] = 1'b1;
        5'b11000: c[7] = 1'b1;
        5'b11011: begin
          c[7] = 1'b1;
          r.isLink = linkReg(rd);
        end
        5'b11001: begin
          c[8:7] = 2'b11;
          r.isLink = linkReg(rd);
          r.isRet = rd == 5'd0 && linkReg(w[19:15]);
        end
        5'b11100: c[9] = 1'b1;
        5'b10100, 5'b10000, 5'b10001, 5'b10010, 5'b10011: c[6] = 1'b1;
        default: c[10] = 1'b1;
      endcase
    end else if (!compEn) begin
      c[10] = 1'b1;
    end else begin
      case ({w[1:0], w[15:13]})
        5'b00_000: begin
          if (w[12:5] != 8'd0) c[0] = 1'b1;
          else c[10] = 1'b1;
        end
        5'b00_001, 5'b10_001: c[5:3] = 3'b101;
        5'b00_010, 5'b00_011, 5'b10_010, 5'b10_011: c[3] = 1'b1;
        5'b00_101, 5'b10_101: c[5:4] = 2'b11;
        5'b00_110, 5'b00_111, 5'b10_110, 5'b10_111: c[4] = 1'b1;
        5'b01_000, 5'b01_001, 5'b01_010, 5'b01_011: c[0] = 1'b1;
        5'b01_100: begin
          if (w[11:10] < 2'b10) c[1] = 1'b1;
          else c[0] = 1'b1;
        end
        5'b01_101, 5'b01_110, 5'b01_111: c[7] = 1'b1;
        5'b10_000: c[1] = 1'b1;
        5'b10_100: begin
          if (w[6:2] != 5'd0) begin
            c[0] = 1'b1;
          end else if (rd != 5'd0) begin
            c[8:7] = 2'b11;
            r.isLink = w[12];
            r.isRet = !w[12] && linkReg(rd);
          end else if (w[12]) begin
            c[9] = 1'b1;
          end else begin
            c[10] = 1'b1;
          end
        end
        default: c[10] = 1'b1;
      endcase
    end
    r.cls = c;
    return r;
  endfunction

  // ******************************
  // Compare tasks
  // ******************************
  task automatic checkInfo(input string name, input rvPredecodePkg::predecInfo_t exp,
                           input rvPredecodePkg::predecInfo_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
      valueErrs++;
    end
  endtask

  task automatic checkInstr(input string name, input rvPredecodePkg::instrWord_t exp,
                            input rvPredecodePkg::instrWord_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
      valueErrs++;
    end
  endtask

  task automatic checkReg(input string name, input rvPredecodePkg::axiData_t exp,
                          input rvPredecodePkg::axiData_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
      valueErrs++;
    end
  endtask

  // ******************************
  // AXI4-Lite tasks
  // ******************************
  task automatic axiWrite(input rvPredecodePkg::axiAddr_t addr,
                          input rvPredecodePkg::axiData_t data);
    int waitCnt;
    logic taken;
    @(negedge clk);
    axiReq.awValid = 1'b1;
    axiReq.awAddr = addr;
    axiReq.wValid = 1'b1;
    axiReq.wData = data;
    axiReq.wStrb = 4'hF;
    axiReq.bReady = 1'b0;
    waitCnt = 0;
    do begin
      @(posedge clk);
      taken = axiRsp.awReady && axiRsp.wReady;
      waitCnt++;
    end while (!taken && waitCnt < respWait);
    if (!taken) begin
      $display("Write address and data not accepted for address 0x%h", addr);
      protoErrs++;
    end
    @(negedge clk);
    axiReq.awValid = 1'b0;
    axiReq.wValid = 1'b0;
    waitCnt = 0;
    while (!axiRsp.bValid && waitCnt < respWait) begin
      @(negedge clk);
      waitCnt++;
    end
    if (axiRsp.bValid) begin
      repeat (respStall) @(negedge clk); // The response waits with bReady low
      axiReq.bReady = 1'b1;
      checkReg("bResp", '0, rvPredecodePkg::axiData_t'(axiRsp.bResp));
      @(posedge clk);
    end else begin
      $display("No write response for address 0x%h", addr);
      protoErrs++;
    end
    @(negedge clk);
    axiReq.bReady = 1'b0;
  endtask

  task automatic axiRead(input rvPredecodePkg::axiAddr_t addr,
                         output rvPredecodePkg::axiData_t data);
    int waitCnt;
    data = '0;
    @(negedge clk);
    axiReq.arValid = 1'b1;
    axiReq.arAddr = addr;
    axiReq.rReady = 1'b0;
    waitCnt = 0;
    do begin
      @(posedge clk);
      waitCnt++;
    end while (!axiRsp.arReady && waitCnt < respWait);
    @(negedge clk);
    axiReq.arValid = 1'b0;
    waitCnt = 0;
    while (!axiRsp.rValid && waitCnt < respWait) begin
      @(negedge clk);
      waitCnt++;
    end
    if (axiRsp.rValid) begin
      repeat (respStall) @(negedge clk); // Read data must hold with rReady low
      axiReq.rReady = 1'b1;
      data = axiRsp.rData;
      checkReg("rResp", '0, rvPredecodePkg::axiData_t'(axiRsp.rResp));
      @(posedge clk);
    end else begin
      $display("No read response for address 0x%h", addr);
      protoErrs++;
    end
    @(negedge clk);
    axiReq.rReady = 1'b0;
  endtask

  task automatic checkCounters();
    rvPredecodePkg::axiData_t d;
    axiRead(`TOTAL_OFS, d);
    checkReg("totalCnt", totalM, d);
    axiRead(`JUMP_OFS, d);
    checkReg("jumpCnt", jumpM, d);
    axiRead(`LOAD_OFS, d);
    checkReg("loadCnt", loadM, d);
    axiRead(`STORE_OFS, d);
    checkReg("storeCnt", storeM, d);
    axiRead(`ILLEGAL_OFS, d);
    checkReg("illegalCnt", illegalM, d);
  endtask

  // ******************************
  // Instruction stream
  // ******************************
  task automatic streamBeats(input int count, input int readyPct, input logic directed);
    int sent;
    logic xfer;
    sent = 0;
    xfer = 1'b0;
    while (sent < count) begin
      @(negedge clk);
      outReady = directed || (nextRand() % 100) < readyPct;
      if (xfer) inValid = 1'b0; // Valid holds until the transfer
      if (!inValid && (directed || (nextRand() % 5) != 0)) begin
        inValid = 1'b1;
        inInstr = directed ? dirWords[sent] : genInstr();
      end
      @(posedge clk);
      xfer = inValid && inReady;
      if (xfer) sent++;
    end
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic drainStream();
    @(negedge clk);
    outReady = 1'b1;
    while (expQ.size() != 0) @(posedge clk);
    @(negedge clk);
  endtask

  function automatic int totalErrors();
    return valueErrs + protoErrs + u_rvPredecodeTop.u_rvPredecodeAssertions.failCount;
  endfunction

  task automatic printSummary();
    $display("Errors: %0d value, %0d protocol, %0d assertion; %0d beats checked",
             valueErrs, protoErrs, u_rvPredecodeTop.u_rvPredecodeAssertions.failCount,
             beatsChecked);
  endtask

  // ******************************
  // Compare process
  // ******************************
  always @(posedge clk) begin
    if (rstN) begin
      if (outValid && outReady) begin
        if (expQ.size() == 0) begin
          $display("Output beat 0x%h arrived with no matching input", outBeat.instr);
          protoErrs++;
        end else begin
          expBeat = expQ.pop_front();
          checkInstr("outBeat.instr", expBeat.instr, outBeat.instr);
          checkInfo("outBeat.info", expBeat.info, outBeat.info);
          beatsChecked++;
          if (countEnM) begin
            totalM = totalM + 1;
            jumpM = jumpM + expBeat.info.cls[7];
            loadM = loadM + expBeat.info.cls[3];
            storeM = storeM + expBeat.info.cls[4];
            illegalM = illegalM + expBeat.info.cls[10];
          end
        end
      end
      if (inValid && inReady) begin
        newBeat.instr = inInstr;
        newBeat.info = refPredecode(inInstr, compEnM);
        expQ.push_back(newBeat);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      printSummary();
      $display("Test failures found");
      $finish;
    end
  end

  // ******************************
  // Main sequence
  // ******************************
  initial begin
    rndState = 32'h4ff5;
    inValid = 1'b0;
    inInstr = '0;
    outReady = 1'b0;
    axiReq = '0;
    compEnM = 1'b1;
    countEnM = 1'b0;
    {totalM, jumpM, loadM, storeM, illegalM} = '0;
    wait (rstN);
    @(negedge clk);

    axiRead(`CTRL_OFS, rdData);
    checkReg("ctrl after reset", 32'h1, rdData);
    axiWrite(`CTRL_OFS, 32'h7); // Counting on, clear bit reads back as 0
    countEnM = 1'b1;
    axiRead(`CTRL_OFS, rdData);
    checkReg("ctrl", 32'h3, rdData);
    axiWrite(8'h40, 32'hFFFFFFFF);
    axiRead(8'h40, rdData);
    checkReg("unmapped 0x40", 32'h0, rdData);
    axiRead(`CTRL_OFS, rdData);
    checkReg("ctrl after unmapped write", 32'h3, rdData);

    streamBeats(numRandBeats, 60, 1'b0);
    drainStream();
    checkCounters();
    axiWrite(`CTRL_OFS, 32'h6);
    axiWrite(`CTRL_OFS, 32'h3);
    {totalM, jumpM, loadM, storeM, illegalM} = '0;
    checkCounters();

    axiWrite(`CTRL_OFS, 32'h2); // Compressed words now illegal
    compEnM = 1'b0;
    streamBeats(numOffBeats, 90, 1'b0);
    drainStream();
    checkCounters();

    axiWrite(`CTRL_OFS, 32'h3);
    compEnM = 1'b1;
    streamBeats(numDirBeats, 100, 1'b1);
    drainStream();
    checkCounters();

    printSummary();
    if (totalErrors() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* rvPredecode.f */
+incdir+logic
logic/rvPredecodePkg.sv
logic/rvClassDecode.sv
logic/predecodePipe.sv
logic/predecodeCsr.sv
logic/rvPredecodeTop.sv
dv/tbClockGen.sv
dv/rvPredecode_assertions.sv
dv/rvPredecodeTb.sv

/* Bender.yml */
package:
  name: rvPredecode

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvPredecodePkg.sv
      - logic/rvClassDecode.sv
      - logic/predecodePipe.sv
      - logic/predecodeCsr.sv
      - logic/rvPredecodeTop.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tbClockGen.sv
      - dv/rvPredecode_assertions.sv
      - dv/rvPredecodeTb.sv
